//--- sim/ex_input.txt
# name rs1 rs2 pc imm fwd class func src_a src_b fwd_a fwd_b csr_we csr_rd csr_addr csr_func
# then the expected alu_out and csr_data_out, every field in hex
add_r      5 7 0 0 0 2 0 0 0 0 0 0 0 0 1 c 0
sub_r      5 7 0 0 0 2 8 0 0 0 0 0 0 0 1 fffffffe 0
addi_f7    5 0 0 400 0 3 8 0 1 0 0 0 0 0 1 405 0
slt_neg    ffffffff 1 0 0 0 2 2 0 0 0 0 0 0 0 1 1 0
sltu_big   ffffffff 1 0 0 0 2 3 0 0 0 0 0 0 0 1 0 0
sra_neg    80000010 0 0 4 0 3 d 0 1 0 0 0 0 0 1 f8000001 0
srl_neg    80000010 0 0 4 0 3 5 0 1 0 0 0 0 0 1 8000001 0
xor_r      ff00ff00 ff00ff0 0 0 0 2 4 0 0 0 0 0 0 0 1 f0f0f0f0 0
andi       ff00ff00 0 0 ff00ff0 0 3 7 0 1 0 0 0 0 0 1 f000f00 0
sll_shamt  1 3f 0 0 0 2 1 0 0 0 0 0 0 0 1 80000000 0
auipc      0 0 1000 12345000 0 0 0 1 1 0 0 0 0 0 1 12346000 0
jal_link   0 0 1000 0 0 0 0 1 2 0 0 0 0 0 1 1004 0
lui        0 0 0 abcde000 0 0 f 2 1 0 0 0 0 0 1 abcde000 0
fwd_a      5 0 1000 20 100 0 0 1 1 1 0 0 0 0 1 120 0
fwd_b      5 3 0 0 100 2 0 0 2 0 1 0 0 0 1 105 0
src_11     9 2 0 0 0 2 0 3 3 0 0 0 0 0 1 b 0
branch     10 3 0 0 0 1 0 0 0 0 0 0 0 0 1 d 0
branch_f4  10 3 0 0 0 1 4 0 0 0 0 0 0 0 1 d 0
csr_reset  0 0 0 0 0 0 0 0 0 0 0 0 1 305 2 0 0
csrrw_ms   12345678 0 0 0 0 0 0 0 0 0 0 1 1 340 1 12345678 0
csrrs_ms   f0 0 0 0 0 0 0 0 0 0 0 1 1 340 2 f0 12345678
csrrc_ms   78 0 0 0 0 0 0 0 0 0 0 1 1 340 3 78 123456f8
csrrwi_tv  0 0 0 1f 0 0 0 0 0 0 0 1 1 305 5 0 0
csrrsi_epc 0 0 0 7 0 0 0 0 0 0 0 1 1 341 6 0 0
csrrci_epc 0 0 0 4 0 0 0 0 0 0 0 1 1 341 7 0 6
rd_epc     0 0 0 0 0 0 0 0 0 0 0 0 1 341 2 0 2
rd_tvec    0 0 0 0 0 0 0 0 0 0 0 0 1 305 2 0 1c
rd_ms      0 0 0 0 0 0 0 0 0 0 0 0 1 340 2 0 12345680
wr_unknown dead 0 0 0 0 0 0 0 0 0 0 1 1 7c0 1 dead 0
rd_unknown 0 0 0 0 0 0 0 0 0 0 0 0 1 7c0 2 0 0
rd_low     0 0 0 0 0 0 0 0 0 0 0 0 0 340 2 0 0
csrrw_tv   ffffffff 0 0 0 0 0 0 0 0 0 0 1 1 305 1 ffffffff 1c
rd_tvec_ff 0 0 0 0 0 0 0 0 0 0 0 0 1 305 2 0 fffffffc

//--- project.f
design/ex_pkg.sv
design/alu_ctrl.sv
design/alu.sv
design/csr_file.sv
design/ex_stage.sv
sim/ex_checker.sv
sim/ex_stage_sva.sv
sim/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - design/ex_pkg.sv
      - design/alu_ctrl.sv
      - design/alu.sv
      - design/csr_file.sv
      - design/ex_stage.sv
  - target: simulation
    files:
      - sim/ex_checker.sv
      - sim/ex_stage_sva.sv
      - sim/tb_ex_stage.sv

//--- sim/tb_ex_stage.sv
module tb_ex_stage
  import ex_pkg::*;
();

  localparam int dwidth      = 32;
  localparam int max_lines   = 200; // Data file line limit
  localparam int settle_wait = 20;

  logic              clk;
  logic              rst_n;
  logic [dwidth-1:0] data_rs1;
  logic [dwidth-1:0] data_rs2;
  logic [dwidth-1:0] data_pc;
  logic [dwidth-1:0] data_imm;
  logic [dwidth-1:0] forward_data_in;
  alu_class_e        alu_class;
  logic [3:0]        alu_func;
  src_a_e            alu_src_a;
  src_b_e            alu_src_b;
  logic              forward_a_sel;
  logic              forward_b_sel;
  logic              csr_we;
  logic              csr_rd;
  logic [11:0]       csr_addr;
  csr_func_e         csr_func;
  logic [dwidth-1:0] alu_out;
  logic [dwidth-1:0] csr_data_out;

  // Vector handed to the checker
  logic              vec_valid;
  logic [8*16-1:0]   vec_name;
  logic [dwidth-1:0] exp_alu;
  logic [dwidth-1:0] exp_csr;
  int                checked;
  int                mismatches;

  int                fd;
  int                n;
  int                lines;
  int                sent;
  int                timeouts;
  int                file_errors;
  int                wait_cycles;
  bit                done;
  string             line;
  logic [8*16-1:0]   name_v;
  logic [31:0]       f [0:16];

  ex_stage #(
    .dwidth (dwidth)
  ) uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_rs1        (data_rs1),
    .data_rs2        (data_rs2),
    .data_pc         (data_pc),
    .data_imm        (data_imm),
    .forward_data_in (forward_data_in),
    .alu_class       (alu_class),
    .alu_func        (alu_func),
    .alu_src_a       (alu_src_a),
    .alu_src_b       (alu_src_b),
    .forward_a_sel   (forward_a_sel),
    .forward_b_sel   (forward_b_sel),
    .csr_we          (csr_we),
    .csr_rd          (csr_rd),
    .csr_addr        (csr_addr),
    .csr_func        (csr_func),
    .alu_out         (alu_out),
    .csr_data_out    (csr_data_out)
  );

  ex_checker #(
    .dwidth (dwidth)
  ) u_checker (
    .clk          (clk),
    .valid        (vec_valid),
    .test_name    (vec_name),
    .exp_alu      (exp_alu),
    .exp_csr      (exp_csr),
    .alu_out      (alu_out),
    .csr_data_out (csr_data_out),
    .checked      (checked),
    .mismatches   (mismatches)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic apply_vector();
    data_rs1        <= f[0];
    data_rs2        <= f[1];
    data_pc         <= f[2];
    data_imm        <= f[3];
    forward_data_in <= f[4];
    alu_class       <= alu_class_e'(f[5][1:0]);
    alu_func        <= f[6][3:0];
    alu_src_a       <= src_a_e'(f[7][1:0]);
    alu_src_b       <= src_b_e'(f[8][1:0]);
    forward_a_sel   <= f[9][0];
    forward_b_sel   <= f[10][0];
    csr_we          <= f[11][0];
    csr_rd          <= f[12][0];
    csr_addr        <= f[13][11:0];
    csr_func        <= csr_func_e'(f[14][2:0]);
    vec_name        <= name_v;
    exp_alu         <= f[15];
    exp_csr         <= f[16];
    vec_valid       <= 1'b1;
  endtask

  initial begin
    rst_n           = 1'b0;
    data_rs1        = '0;
    data_rs2        = '0;
    data_pc         = '0;
    data_imm        = '0;
    forward_data_in = '0;
    alu_class       = class_add;
    alu_func        = 4'h0;
    alu_src_a       = src_a_rs1;
    alu_src_b       = src_b_rs2;
    forward_a_sel   = 1'b0;
    forward_b_sel   = 1'b0;
    csr_we          = 1'b0;
    csr_rd          = 1'b0;
    csr_addr        = '0;
    csr_func        = csrrw;
    vec_valid       = 1'b0;
    vec_name        = '0;
    exp_alu         = '0;
    exp_csr         = '0;
    sent            = 0;
    timeouts        = 0;
    file_errors     = 0;

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    fd = $fopen("sim/ex_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the data file sim/ex_input.txt");
      file_errors++;
    end else begin
      lines = 0;
      done  = 1'b0;
      while (!done) begin
        if (lines == max_lines) begin
          $display("timeout: data file not finished after %0d lines", max_lines);
          timeouts++;
          done = 1'b1;
        end else if ($fgets(line, fd) == 0) begin
          done = 1'b1;
        end else begin
          lines++;
          if (line.len() > 1 && line[0] != "#") begin // Skip blanks and comments
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name_v, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
            if (n != 18) begin
              $display("line %0d of the data file has %0d fields instead of 18", lines, n);
              file_errors++;
            end else begin
              @(posedge clk);
              apply_vector();
              sent++;
            end
          end
        end
      end
      $fclose(fd);
    end

    @(posedge clk);
    vec_valid <= 1'b0;

    // Last vector is compared one edge after it was applied
    wait_cycles = 0;
    while (checked != sent && wait_cycles < settle_wait) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (checked != sent) begin
      $display("timeout: checker compared only %0d of %0d vectors", checked, sent);
      timeouts++;
    end

    $display("vectors %0d, mismatches %0d, assertion failures %0d, timeouts %0d, file errors %0d",
             sent, mismatches, uut.u_sva.fails, timeouts, file_errors);
    if (mismatches == 0 && uut.u_sva.fails == 0 && timeouts == 0 && file_errors == 0
        && sent > 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- sim/ex_stage_sva.sv
module ex_stage_sva
  import ex_pkg::*;
#(
  parameter int dwidth = 32
) (
  input logic              clk,
  input logic              rst_n,
  input logic [dwidth-1:0] data_imm,
  input logic [dwidth-1:0] forward_data_in,
  input logic [dwidth-1:0] alu_out,
  input logic [dwidth-1:0] csr_data_out,
  input alu_class_e        alu_class,
  input logic [3:0]        alu_func,
  input src_b_e            alu_src_b,
  input logic              forward_a_sel,
  input logic              forward_b_sel,
  input logic              csr_rd,
  input logic [11:0]       csr_addr
);

  int fails = 0;

  csr_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
    !csr_rd |-> csr_data_out == '0)
    else begin
      fails++;
      $error("csr_data_out is not zero while csr_rd is low");
    end

  mtvec_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    csr_rd && csr_addr == csr_mtvec |-> csr_data_out[1:0] == 2'b00)
    else begin
      fails++;
      $error("mtvec read back with its low two bits set");
    end

  // Forwarded base plus offset, as for a load or store address
  fwd_add_imm: assert property (@(posedge clk) disable iff (!rst_n)
    forward_a_sel && !forward_b_sel && alu_src_b == src_b_imm && alu_class == class_add
      && alu_func != func_lui |-> alu_out == forward_data_in + data_imm)
    else begin
      fails++;
      $error("alu_out is not forward_data_in plus data_imm");
    end

endmodule

bind ex_stage ex_stage_sva #(.dwidth(dwidth)) u_sva (.*);

//--- sim/ex_checker.sv
module ex_checker #(
  parameter int dwidth = 32
) (
  input  logic              clk,
  input  logic              valid,
  input  logic [8*16-1:0]   test_name,
  input  logic [dwidth-1:0] exp_alu,
  input  logic [dwidth-1:0] exp_csr,
  input  logic [dwidth-1:0] alu_out,
  input  logic [dwidth-1:0] csr_data_out,
  output int                checked,
  output int                mismatches
);

  int    n_checked = 0;
  int    n_bad     = 0;
  int    bad;
  string name;

  assign checked    = n_checked;
  assign mismatches = n_bad;

  function automatic int compare_value(string tname, string port,
                                       logic [dwidth-1:0] expected,
                                       logic [dwidth-1:0] actual);
    if (actual !== expected) begin
      $display("error %s %s: expected %h, actual %h", tname, port, expected, actual);
      return 1;
    end
    return 0;
  endfunction

  // Outputs still show the vector applied at the previous edge,
  // and the CSR read still shows the value before this edge's write
  always @(posedge clk) begin
    if (valid) begin
      name = string'(test_name); // Leading null bytes dropped
      bad  = compare_value(name, "alu_out", exp_alu, alu_out);
      bad  = bad + compare_value(name, "csr_data_out", exp_csr, csr_data_out);
      n_checked <= n_checked + 1;
      n_bad     <= n_bad + bad;
    end
  end

endmodule

//--- design/ex_stage.sv
module ex_stage
  import ex_pkg::*;
#(
  parameter int dwidth = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [dwidth-1:0] data_rs1,
  input  logic [dwidth-1:0] data_rs2,
  input  logic [dwidth-1:0] data_pc,
  input  logic [dwidth-1:0] data_imm,
  input  logic [dwidth-1:0] forward_data_in,
  input  alu_class_e        alu_class,
  input  logic [3:0]        alu_func,
  input  src_a_e            alu_src_a,
  input  src_b_e            alu_src_b,
  input  logic              forward_a_sel,
  input  logic              forward_b_sel,
  input  logic              csr_we,
  input  logic              csr_rd,
  input  logic [11:0]       csr_addr,
  input  csr_func_e         csr_func,
  output logic [dwidth-1:0] alu_out,
  output logic [dwidth-1:0] csr_data_out
);

  localparam logic [dwidth-1:0] const_four = dwidth'(4);

  logic [dwidth-1:0] sel_a;
  logic [dwidth-1:0] sel_b;
  logic [dwidth-1:0] alu_a;
  logic [dwidth-1:0] alu_b;
  logic [dwidth-1:0] rs1_val;
  logic [dwidth-1:0] csr_wdata;
  alu_op_e           alu_op;

  always_comb begin
    case (alu_src_a)
      src_a_rs1:  sel_a = data_rs1;
      src_a_pc:   sel_a = data_pc;  // AUIPC, JAL
      src_a_zero: sel_a = '0;
      default:    sel_a = data_rs1;
    endcase
  end

  always_comb begin
    case (alu_src_b)
      src_b_rs2:  sel_b = data_rs2;
      src_b_imm:  sel_b = data_imm;
      src_b_four: sel_b = const_four; // Link address
      default:    sel_b = data_rs2;
    endcase
  end

  // Forwarding beats the source selects
  assign alu_a = forward_a_sel ? forward_data_in : sel_a;
  assign alu_b = forward_b_sel ? forward_data_in : sel_b;

  // rs1 as the CSR source sees the same forwarding as operand A
  assign rs1_val = forward_a_sel ? forward_data_in : data_rs1;

  // Immediate forms carry the 5-bit zimm
  assign csr_wdata = csr_func[2] ? {{(dwidth-5){1'b0}}, data_imm[4:0]} : rs1_val;

  alu_ctrl u_alu_ctrl (
    .alu_class (alu_class),
    .func      (alu_func),
    .alu_op    (alu_op)
  );

  alu #(
    .dwidth (dwidth)
  ) u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .alu_op (alu_op),
    .result (alu_out)
  );

  csr_file #(
    .dwidth (dwidth)
  ) u_csr_file (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (csr_we),
    .rd    (csr_rd),
    .addr  (csr_addr),
    .func  (csr_func),
    .wdata (csr_wdata),
    .rdata (csr_data_out)
  );

endmodule

//--- design/csr_file.sv
module csr_file
  import ex_pkg::*;
#(
  parameter int dwidth = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we,
  input  logic              rd,
  input  logic [11:0]       addr,
  input  csr_func_e         func,
  input  logic [dwidth-1:0] wdata,
  output logic [dwidth-1:0] rdata
);

  // Write masks at the data width
  localparam logic [dwidth-1:0] mtvec_wmask = dwidth'(mtvec_mask);
  localparam logic [dwidth-1:0] mepc_wmask  = {{(dwidth-1){1'b1}}, 1'b0};

  logic [dwidth-1:0] mscratch_q;
  logic [dwidth-1:0] mtvec_q;
  logic [dwidth-1:0] mepc_q;

  logic [dwidth-1:0] cur_val;
  logic [dwidth-1:0] new_val;

  // Current value of the addressed register, zero if unknown
  always_comb begin
    case (addr)
      csr_mscratch: cur_val = mscratch_q;
      csr_mtvec:    cur_val = mtvec_q;
      csr_mepc:     cur_val = mepc_q;
      default:      cur_val = '0;
    endcase
  end

  // Read-modify-write value
  always_comb begin
    case (func)
      csrrw, csrrwi: new_val = wdata;
      csrrs, csrrsi: new_val = cur_val | wdata;
      csrrc, csrrci: new_val = cur_val & ~wdata;
      default:       new_val = cur_val;
    endcase
  end

  // Old value goes out while the new one lands at the edge
  assign rdata = rd ? cur_val : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mscratch_q <= '0;
      mtvec_q    <= '0;
      mepc_q     <= '0;
    end else if (we) begin
      case (addr)
        csr_mscratch: mscratch_q <= new_val;
        csr_mtvec:    mtvec_q    <= new_val & mtvec_wmask;
        csr_mepc:     mepc_q     <= new_val & mepc_wmask; // Halfword aligned
        default: begin
          // Unknown address, nothing written
          mscratch_q <= mscratch_q;
        end
      endcase
    end
  end

endmodule

//--- design/alu.sv
module alu
  import ex_pkg::*;
#(
  parameter int dwidth = 32
) (
  input  logic [dwidth-1:0] a,
  input  logic [dwidth-1:0] b,
  input  alu_op_e           alu_op,
  output logic [dwidth-1:0] result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (alu_op)
      op_add: result = a + b;
      op_sub: result = a - b;
      op_sll: result = a << shamt;
      op_slt: begin
        result = {{(dwidth-1){1'b0}}, lt_signed};
      end
      op_sltu: begin
        result = {{(dwidth-1){1'b0}}, lt_unsigned};
      end
      op_xor: result = a ^ b;
      op_srl: result = a >> shamt;
      op_sra: result = $unsigned($signed(a) >>> shamt); // Sign fill
      op_or:  result = a | b;
      op_and: result = a & b;
      op_pass_b: result = b;
      default: result = '0;
    endcase
  end

endmodule

//--- design/alu_ctrl.sv
module alu_ctrl
  import ex_pkg::*;
(
  input  alu_class_e alu_class,
  input  logic [3:0] func,      // {funct7[5], funct3}
  output alu_op_e    alu_op
);

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  logic       f7_bit;
  logic [2:0] funct3;
  alu_op_e    shift_r_op;
  alu_op_e    base_op;

  assign f7_bit = func[3];
  assign funct3 = func[2:0];

  // Right shifts read the funct7 bit in both R and I forms
  assign shift_r_op = f7_bit ? op_sra : op_srl;

  // Decode of funct3 common to R and I types
  always_comb begin
    case (funct3)
      f3_add_sub: base_op = op_add;
      f3_sll:     base_op = op_sll;
      f3_slt:     base_op = op_slt;
      f3_sltu:    base_op = op_sltu;
      f3_xor:     base_op = op_xor;
      f3_srl_sra: base_op = shift_r_op;
      f3_or:      base_op = op_or;
      f3_and:     base_op = op_and;
      default:    base_op = op_add;
    endcase
  end

  always_comb begin
    case (alu_class)
      class_add: begin
        alu_op = (func == func_lui) ? op_pass_b : op_add;
      end
      class_branch_sub: alu_op = op_sub;
      class_r_type: begin
        if (funct3 == f3_add_sub && f7_bit) alu_op = op_sub;
        else alu_op = base_op;
      end
      class_i_type: alu_op = base_op; // ADDI with imm[10] set stays add
      default: alu_op = op_add;
    endcase
  end

endmodule

//--- design/ex_pkg.sv
package ex_pkg;

  // ALU class from the main decoder
  typedef enum logic [1:0] {
    class_add        = 2'b00, // Loads, stores, AUIPC, JAL, LUI
    class_branch_sub = 2'b01,
    class_r_type     = 2'b10,
    class_i_type     = 2'b11
  } alu_class_e;

  // Func field value that selects pass_b in the add class
  // Never a real load or store funct3, so it is free for LUI
  localparam logic [3:0] func_lui = 4'b1111;

  typedef enum logic [3:0] {
    op_add    = 4'd0,
    op_sub    = 4'd1,
    op_sll    = 4'd2,
    op_slt    = 4'd3,
    op_sltu   = 4'd4,
    op_xor    = 4'd5,
    op_srl    = 4'd6,
    op_sra    = 4'd7,
    op_or     = 4'd8,
    op_and    = 4'd9,
    op_pass_b = 4'd10  // LUI
  } alu_op_e;

  // Operand A source, 11 behaves as rs1
  typedef enum logic [1:0] {
    src_a_rs1  = 2'b00,
    src_a_pc   = 2'b01,
    src_a_zero = 2'b10
  } src_a_e;

  // Operand B source, 11 behaves as rs2
  typedef enum logic [1:0] {
    src_b_rs2  = 2'b00,
    src_b_imm  = 2'b01,
    src_b_four = 2'b10
  } src_b_e;

  // funct3 of SYSTEM, bit 2 marks the immediate forms
  typedef enum logic [2:0] {
    csrrw  = 3'd1,
    csrrs  = 3'd2,
    csrrc  = 3'd3,
    csrrwi = 3'd5,
    csrrsi = 3'd6,
    csrrci = 3'd7
  } csr_func_e;

  localparam logic [11:0] csr_mscratch = 12'h340;
  localparam logic [11:0] csr_mtvec    = 12'h305;
  localparam logic [11:0] csr_mepc     = 12'h341;

  // Low two bits of mtvec forced to zero
  // Signed so that it extends with ones to any data width
  localparam logic signed [31:0] mtvec_mask = -32'sd4;

endpackage
